/* ctrl_pkg.sv */
// shared codes for the pipeline controller; encodings must match the fetch stage and ID muxes
package ctrl_pkg;

  //////////////////////////////////////////////////
  // fetch stage PC select
  //////////////////////////////////////////////////

  localparam int PC_SEL_W = 3;

  // boot address after reset or wake-up
  localparam logic [PC_SEL_W-1:0] PC_BOOT      = 3'b000;
  // jump target computed in ID
  localparam logic [PC_SEL_W-1:0] PC_JUMP      = 3'b010;
  // conditional branch target resolved in EX
  localparam logic [PC_SEL_W-1:0] PC_BRANCH    = 3'b011;
  localparam logic [PC_SEL_W-1:0] PC_EXCEPTION = 3'b100;
  // return address of mret
  localparam logic [PC_SEL_W-1:0] PC_ERET      = 3'b101;

  //////////////////////////////////////////////////
  // operand forwarding select
  //////////////////////////////////////////////////

  localparam int FWD_SEL_W = 2;

  localparam logic [FWD_SEL_W-1:0] SEL_REGFILE = 2'b00;
  localparam logic [FWD_SEL_W-1:0] SEL_FW_EX   = 2'b01;
  localparam logic [FWD_SEL_W-1:0] SEL_FW_WB   = 2'b10;

  //////////////////////////////////////////////////
  // jump kind from the decoder
  //////////////////////////////////////////////////

  localparam int JUMP_W = 2;

  localparam logic [JUMP_W-1:0] BRANCH_NONE = 2'b00;
  localparam logic [JUMP_W-1:0] BRANCH_JAL  = 2'b01;
  localparam logic [JUMP_W-1:0] BRANCH_JALR = 2'b10;
  localparam logic [JUMP_W-1:0] BRANCH_COND = 2'b11;

  //////////////////////////////////////////////////
  // controller FSM states, code 7 is unused
  //////////////////////////////////////////////////

  localparam int STATE_W = 3;

  localparam logic [STATE_W-1:0] ST_RESET       = 3'd0;
  localparam logic [STATE_W-1:0] ST_BOOT_SET    = 3'd1;
  localparam logic [STATE_W-1:0] ST_SLEEP       = 3'd2;
  localparam logic [STATE_W-1:0] ST_FIRST_FETCH = 3'd3;
  localparam logic [STATE_W-1:0] ST_DECODE      = 3'd4;
  localparam logic [STATE_W-1:0] ST_FLUSH_EX    = 3'd5;
  localparam logic [STATE_W-1:0] ST_FLUSH_WB    = 3'd6;

endpackage

/* ctrl_fsm.sv */
// all outputs are combinational from state and inputs; branch_taken_ex_i must never repeat
module ctrl_fsm (
  input  logic                         clk,
  input  logic                         rst_n,

  input  logic                         fetch_enable_i,
  input  logic                         mret_insn_i,
  input  logic                         pipe_flush_i,
  input  logic                         instr_valid_i,
  input  logic                         branch_taken_ex_i,
  input  logic                         int_req_i,
  input  logic                         ext_req_i,
  input  logic                         id_ready_i,
  input  logic                         ex_valid_i,
  input  logic                         jr_stall_i,
  input  logic [ctrl_pkg::JUMP_W-1:0]  jump_in_dec_i,

  output logic                         ctrl_busy_o,
  output logic                         is_decoding_o,
  output logic                         instr_req_o,
  output logic                         pc_set_o,
  output logic [ctrl_pkg::PC_SEL_W-1:0] pc_mux_o,
  output logic                         exc_ack_o,
  output logic                         irq_ack_o,
  output logic                         exc_save_if_o,
  output logic                         exc_save_id_o,
  output logic                         exc_save_takenbranch_o,
  output logic                         exc_restore_id_o,
  output logic                         halt_if_o,
  output logic                         halt_id_o
);

  logic [ctrl_pkg::STATE_W-1:0] state_q;
  logic [ctrl_pkg::STATE_W-1:0] state_d;
  logic                         jump_done_q;
  logic                         jump_done;
  logic                         exc_req;
  logic                         jump_uncond;

  assign exc_req = int_req_i | ext_req_i;

  // only JAL and JALR are resolved in ID, conditional branches go to EX
  always_comb begin
    case (jump_in_dec_i)
      ctrl_pkg::BRANCH_JAL,
      ctrl_pkg::BRANCH_JALR: jump_uncond = 1'b1;
      ctrl_pkg::BRANCH_COND,
      ctrl_pkg::BRANCH_NONE: jump_uncond = 1'b0;
      default:               jump_uncond = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // next state and output decode
  //////////////////////////////////////////////////

  always_comb begin
    // defaults: busy and fetching, nothing redirected
    state_d                = state_q;
    jump_done              = jump_done_q;
    ctrl_busy_o            = 1'b1;
    instr_req_o            = 1'b1;
    is_decoding_o          = 1'b0;
    pc_set_o               = 1'b0;
    pc_mux_o               = ctrl_pkg::PC_BOOT;
    exc_ack_o              = 1'b0;
    irq_ack_o              = 1'b0;
    exc_save_if_o          = 1'b0;
    exc_save_id_o          = 1'b0;
    exc_save_takenbranch_o = 1'b0;
    exc_restore_id_o       = 1'b0;
    halt_if_o              = 1'b0;
    halt_id_o              = 1'b0;

    case (state_q)
      ctrl_pkg::ST_RESET: begin
        // idle until the core is enabled
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = ctrl_pkg::ST_BOOT_SET;
        end
      end

      ctrl_pkg::ST_BOOT_SET: begin
        // load boot address into the prefetcher
        pc_mux_o = ctrl_pkg::PC_BOOT;
        pc_set_o = 1'b1;
        state_d  = ctrl_pkg::ST_FIRST_FETCH;
      end

      ctrl_pkg::ST_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        // wake on enable or any pending exception
        if (fetch_enable_i || exc_req) begin
          state_d = ctrl_pkg::ST_FIRST_FETCH;
        end
      end

      ctrl_pkg::ST_FIRST_FETCH: begin
        // wait out the IF miss
        if (id_ready_i) begin
          state_d = ctrl_pkg::ST_DECODE;
        end
        // pipe is empty here, so the IF pc is the one to save
        if (exc_req) begin
          pc_mux_o      = ctrl_pkg::PC_EXCEPTION;
          pc_set_o      = 1'b1;
          exc_ack_o     = 1'b1;
          irq_ack_o     = ext_req_i;
          exc_save_if_o = 1'b1;
        end
      end

      ctrl_pkg::ST_DECODE: begin
        // a taken branch in EX kills the instruction in ID
        if (instr_valid_i && !branch_taken_ex_i) begin
          is_decoding_o = 1'b1;

          if (jump_uncond) begin
            pc_mux_o = ctrl_pkg::PC_JUMP;
            // issue once, and only after the target register is ready
            if (!jr_stall_i && !jump_done_q) begin
              pc_set_o  = 1'b1;
              jump_done = 1'b1;
            end
          end else if (exc_req) begin
            // internal request wins over external
            pc_mux_o      = ctrl_pkg::PC_EXCEPTION;
            pc_set_o      = 1'b1;
            exc_ack_o     = 1'b1;
            irq_ack_o     = !int_req_i;
            halt_id_o     = 1'b1;
            exc_save_id_o = 1'b1;
          end

          if (mret_insn_i) begin
            pc_mux_o         = ctrl_pkg::PC_ERET;
            exc_restore_id_o = 1'b1;
            if (!jump_done_q) begin
              pc_set_o  = 1'b1;
              jump_done = 1'b1;
            end
          end

          // WFI, or mret back into sleep
          if (pipe_flush_i || (mret_insn_i && !fetch_enable_i)) begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = ctrl_pkg::ST_FLUSH_EX;
          end
        end

        // no instruction in ID, save the IF pc for an external request
        if (!instr_valid_i && !branch_taken_ex_i && ext_req_i) begin
          pc_mux_o      = ctrl_pkg::PC_EXCEPTION;
          pc_set_o      = 1'b1;
          exc_ack_o     = 1'b1;
          irq_ack_o     = 1'b1;
          halt_id_o     = 1'b1;
          exc_save_if_o = 1'b1;
        end

        if (branch_taken_ex_i) begin
          pc_mux_o = ctrl_pkg::PC_BRANCH;
          pc_set_o = 1'b1;
          // an external request takes the branch target as return address
          if (ext_req_i) begin
            pc_mux_o               = ctrl_pkg::PC_EXCEPTION;
            exc_ack_o              = 1'b1;
            irq_ack_o              = 1'b1;
            halt_id_o              = 1'b1;
            exc_save_takenbranch_o = 1'b1;
          end
        end
      end

      ctrl_pkg::ST_FLUSH_EX: begin
        // bubble into EX until it drains
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i) begin
          state_d = ctrl_pkg::ST_FLUSH_WB;
        end
      end

      ctrl_pkg::ST_FLUSH_WB: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (fetch_enable_i) begin
          halt_if_o = 1'b0;
          state_d   = ctrl_pkg::ST_DECODE;
        end else begin
          state_d = ctrl_pkg::ST_SLEEP;
        end
      end

      default: begin
        // unused code, recover through reset state
        instr_req_o = 1'b0;
        state_d     = ctrl_pkg::ST_RESET;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // state and jump-done registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= ctrl_pkg::ST_RESET;
      jump_done_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      // held while ID is stalled so the jump is not reissued
      jump_done_q <= jump_done & ~id_ready_i;
    end
  end

endmodule

/* hazard_unit.sv */
// purely combinational; match bits must already be qualified by the decoder's register use
module hazard_unit (
  input  logic                        is_decoding_i,
  input  logic                        illegal_insn_i,
  input  logic                        data_req_ex_i,
  input  logic                        regfile_we_ex_i,
  input  logic                        regfile_we_wb_i,
  input  logic                        regfile_alu_we_fw_i,
  input  logic [ctrl_pkg::JUMP_W-1:0] jump_in_dec_i,

  input  logic                        reg_d_ex_is_reg_a_i,
  input  logic                        reg_d_ex_is_reg_b_i,
  input  logic                        reg_d_ex_is_reg_c_i,
  input  logic                        reg_d_wb_is_reg_a_i,
  input  logic                        reg_d_wb_is_reg_b_i,
  input  logic                        reg_d_wb_is_reg_c_i,
  input  logic                        reg_d_alu_is_reg_a_i,
  input  logic                        reg_d_alu_is_reg_b_i,
  input  logic                        reg_d_alu_is_reg_c_i,

  output logic                        load_stall_o,
  output logic                        jr_stall_o,
  output logic                        deassert_we_o
);

  logic ex_hits_any;
  logic a_pending;

  // EX destination read by any operand of the ID instruction
  assign ex_hits_any = reg_d_ex_is_reg_a_i | reg_d_ex_is_reg_b_i | reg_d_ex_is_reg_c_i;

  // load data only arrives in WB, so no forward can cover it
  assign load_stall_o = data_req_ex_i & regfile_we_ex_i & ex_hits_any;

  // operand A of JALR still in flight somewhere down the pipe
  assign a_pending = (regfile_we_wb_i & reg_d_wb_is_reg_a_i) |
                     (regfile_we_ex_i & reg_d_ex_is_reg_a_i) |
                     (regfile_alu_we_fw_i & reg_d_alu_is_reg_a_i);

  // JALR target goes straight to the PC, it is never forwarded
  assign jr_stall_o = (jump_in_dec_i == ctrl_pkg::BRANCH_JALR) & a_pending;

  // kill the write of anything that does not really retire from ID
  assign deassert_we_o = ~is_decoding_i | illegal_insn_i | load_stall_o | jr_stall_o;

endmodule

/* fwd_unit.sv */
// purely combinational; ALU path forward beats WB, misaligned and multicycle overrides beat both
module fwd_unit (
  input  logic                           regfile_we_wb_i,
  input  logic                           regfile_alu_we_fw_i,
  input  logic                           data_misaligned_i,
  input  logic                           mult_multicycle_i,

  input  logic                           reg_d_wb_is_reg_a_i,
  input  logic                           reg_d_wb_is_reg_b_i,
  input  logic                           reg_d_wb_is_reg_c_i,
  input  logic                           reg_d_alu_is_reg_a_i,
  input  logic                           reg_d_alu_is_reg_b_i,
  input  logic                           reg_d_alu_is_reg_c_i,

  output logic [ctrl_pkg::FWD_SEL_W-1:0] operand_a_fw_mux_sel_o,
  output logic [ctrl_pkg::FWD_SEL_W-1:0] operand_b_fw_mux_sel_o,
  output logic [ctrl_pkg::FWD_SEL_W-1:0] operand_c_fw_mux_sel_o
);

  always_comb begin
    operand_a_fw_mux_sel_o = ctrl_pkg::SEL_REGFILE;
    operand_b_fw_mux_sel_o = ctrl_pkg::SEL_REGFILE;
    operand_c_fw_mux_sel_o = ctrl_pkg::SEL_REGFILE;

    // WB -> ID, oldest result
    if (regfile_we_wb_i) begin
      if (reg_d_wb_is_reg_a_i) operand_a_fw_mux_sel_o = ctrl_pkg::SEL_FW_WB;
      if (reg_d_wb_is_reg_b_i) operand_b_fw_mux_sel_o = ctrl_pkg::SEL_FW_WB;
      if (reg_d_wb_is_reg_c_i) operand_c_fw_mux_sel_o = ctrl_pkg::SEL_FW_WB;
    end

    // EX -> ID, younger result overrides WB
    if (regfile_alu_we_fw_i) begin
      if (reg_d_alu_is_reg_a_i) operand_a_fw_mux_sel_o = ctrl_pkg::SEL_FW_EX;
      if (reg_d_alu_is_reg_b_i) operand_b_fw_mux_sel_o = ctrl_pkg::SEL_FW_EX;
      if (reg_d_alu_is_reg_c_i) operand_c_fw_mux_sel_o = ctrl_pkg::SEL_FW_EX;
    end

    // second half of a misaligned access reuses the address from EX
    if (data_misaligned_i) begin
      operand_a_fw_mux_sel_o = ctrl_pkg::SEL_FW_EX;
      operand_b_fw_mux_sel_o = ctrl_pkg::SEL_REGFILE;
    end else if (mult_multicycle_i) begin
      // multiplier keeps its partial result on operand C
      operand_c_fw_mux_sel_o = ctrl_pkg::SEL_FW_EX;
    end
  end

endmodule

/* core_controller.sv */
// top of the controller; no registers outside ctrl_fsm, all outputs settle in the same cycle
module core_controller (
  input  logic                           clk,
  input  logic                           rst_n,

  input  logic                           fetch_enable_i,
  input  logic                           illegal_insn_i,
  input  logic                           mret_insn_i,
  input  logic                           pipe_flush_i,
  input  logic                           instr_valid_i,
  input  logic                           data_req_ex_i,
  input  logic                           data_misaligned_i,
  input  logic                           mult_multicycle_i,
  input  logic                           branch_taken_ex_i,
  input  logic                           int_req_i,
  input  logic                           ext_req_i,
  input  logic                           id_ready_i,
  input  logic                           ex_valid_i,
  input  logic                           regfile_we_ex_i,
  input  logic                           regfile_we_wb_i,
  input  logic                           regfile_alu_we_fw_i,
  input  logic [ctrl_pkg::JUMP_W-1:0]    jump_in_dec_i,

  input  logic                           reg_d_ex_is_reg_a_i,
  input  logic                           reg_d_ex_is_reg_b_i,
  input  logic                           reg_d_ex_is_reg_c_i,
  input  logic                           reg_d_wb_is_reg_a_i,
  input  logic                           reg_d_wb_is_reg_b_i,
  input  logic                           reg_d_wb_is_reg_c_i,
  input  logic                           reg_d_alu_is_reg_a_i,
  input  logic                           reg_d_alu_is_reg_b_i,
  input  logic                           reg_d_alu_is_reg_c_i,

  output logic                           ctrl_busy_o,
  output logic                           is_decoding_o,
  output logic                           deassert_we_o,
  output logic                           instr_req_o,
  output logic                           pc_set_o,
  output logic [ctrl_pkg::PC_SEL_W-1:0]  pc_mux_o,
  output logic                           exc_ack_o,
  output logic                           irq_ack_o,
  output logic                           exc_save_if_o,
  output logic                           exc_save_id_o,
  output logic                           exc_save_takenbranch_o,
  output logic                           exc_restore_id_o,
  output logic                           halt_if_o,
  output logic                           halt_id_o,
  output logic                           jr_stall_o,
  output logic                           load_stall_o,
  output logic [ctrl_pkg::FWD_SEL_W-1:0] operand_a_fw_mux_sel_o,
  output logic [ctrl_pkg::FWD_SEL_W-1:0] operand_b_fw_mux_sel_o,
  output logic [ctrl_pkg::FWD_SEL_W-1:0] operand_c_fw_mux_sel_o
);

  //////////////////////////////////////////////////
  // sequencing FSM
  //////////////////////////////////////////////////

  ctrl_fsm u_ctrl_fsm (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .fetch_enable_i         (fetch_enable_i),
    .mret_insn_i            (mret_insn_i),
    .pipe_flush_i           (pipe_flush_i),
    .instr_valid_i          (instr_valid_i),
    .branch_taken_ex_i      (branch_taken_ex_i),
    .int_req_i              (int_req_i),
    .ext_req_i              (ext_req_i),
    .id_ready_i             (id_ready_i),
    .ex_valid_i             (ex_valid_i),
    // jump waits on the hazard unit
    .jr_stall_i             (jr_stall_o),
    .jump_in_dec_i          (jump_in_dec_i),
    .ctrl_busy_o            (ctrl_busy_o),
    .is_decoding_o          (is_decoding_o),
    .instr_req_o            (instr_req_o),
    .pc_set_o               (pc_set_o),
    .pc_mux_o               (pc_mux_o),
    .exc_ack_o              (exc_ack_o),
    .irq_ack_o              (irq_ack_o),
    .exc_save_if_o          (exc_save_if_o),
    .exc_save_id_o          (exc_save_id_o),
    .exc_save_takenbranch_o (exc_save_takenbranch_o),
    .exc_restore_id_o       (exc_restore_id_o),
    .halt_if_o              (halt_if_o),
    .halt_id_o              (halt_id_o)
  );

  //////////////////////////////////////////////////
  // stalls and forwarding
  //////////////////////////////////////////////////

  hazard_unit u_hazard_unit (
    .is_decoding_i        (is_decoding_o),
    .illegal_insn_i       (illegal_insn_i),
    .data_req_ex_i        (data_req_ex_i),
    .regfile_we_ex_i      (regfile_we_ex_i),
    .regfile_we_wb_i      (regfile_we_wb_i),
    .regfile_alu_we_fw_i  (regfile_alu_we_fw_i),
    .jump_in_dec_i        (jump_in_dec_i),
    .reg_d_ex_is_reg_a_i  (reg_d_ex_is_reg_a_i),
    .reg_d_ex_is_reg_b_i  (reg_d_ex_is_reg_b_i),
    .reg_d_ex_is_reg_c_i  (reg_d_ex_is_reg_c_i),
    .reg_d_wb_is_reg_a_i  (reg_d_wb_is_reg_a_i),
    .reg_d_wb_is_reg_b_i  (reg_d_wb_is_reg_b_i),
    .reg_d_wb_is_reg_c_i  (reg_d_wb_is_reg_c_i),
    .reg_d_alu_is_reg_a_i (reg_d_alu_is_reg_a_i),
    .reg_d_alu_is_reg_b_i (reg_d_alu_is_reg_b_i),
    .reg_d_alu_is_reg_c_i (reg_d_alu_is_reg_c_i),
    .load_stall_o         (load_stall_o),
    .jr_stall_o           (jr_stall_o),
    .deassert_we_o        (deassert_we_o)
  );

  fwd_unit u_fwd_unit (
    .regfile_we_wb_i        (regfile_we_wb_i),
    .regfile_alu_we_fw_i    (regfile_alu_we_fw_i),
    .data_misaligned_i      (data_misaligned_i),
    .mult_multicycle_i      (mult_multicycle_i),
    .reg_d_wb_is_reg_a_i    (reg_d_wb_is_reg_a_i),
    .reg_d_wb_is_reg_b_i    (reg_d_wb_is_reg_b_i),
    .reg_d_wb_is_reg_c_i    (reg_d_wb_is_reg_c_i),
    .reg_d_alu_is_reg_a_i   (reg_d_alu_is_reg_a_i),
    .reg_d_alu_is_reg_b_i   (reg_d_alu_is_reg_b_i),
    .reg_d_alu_is_reg_c_i   (reg_d_alu_is_reg_c_i),
    .operand_a_fw_mux_sel_o (operand_a_fw_mux_sel_o),
    .operand_b_fw_mux_sel_o (operand_b_fw_mux_sel_o),
    .operand_c_fw_mux_sel_o (operand_c_fw_mux_sel_o)
  );

endmodule

/* controller_props.sv */
// bound into core_controller; state is probed inside ctrl_fsm, inputs are assumed never X after reset
module controller_props (
  input logic                         clk,
  input logic                         rst_n,
  input logic                         branch_taken_i,
  input logic                         exc_ack_i,
  input logic                         pc_set_i,
  input logic                         load_stall_i,
  input logic                         deassert_we_i,
  input logic [ctrl_pkg::STATE_W-1:0] state_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // EX never resolves two taken branches back to back
  a_branch_single: assert property (@(posedge clk) disable iff (!rst_n)
    branch_taken_i |=> !branch_taken_i)
    else $error("branch_taken_ex_i was high on two consecutive cycles");

  // every exception acknowledge redirects fetch
  a_ack_sets_pc: assert property (@(posedge clk) disable iff (!rst_n)
    exc_ack_i |-> pc_set_i)
    else $error("exc_ack_o without pc_set_o");

  a_load_kills_we: assert property (@(posedge clk) disable iff (!rst_n)
    load_stall_i |-> deassert_we_i)
    else $error("load_stall_o without deassert_we_o");

  // first edge after reset release
  a_reset_state: assert property (@(posedge clk)
    $rose(rst_n) |-> (state_i == ctrl_pkg::ST_RESET) && !pc_set_i)
    else $error("controller not idle in reset state after reset release");

endmodule

bind core_controller controller_props u_props (
  .clk            (clk),
  .rst_n          (rst_n),
  .branch_taken_i (branch_taken_ex_i),
  .exc_ack_i      (exc_ack_o),
  .pc_set_i       (pc_set_o),
  .load_stall_i   (load_stall_o),
  .deassert_we_i  (deassert_we_o),
  .state_i        (u_ctrl_fsm.state_q)
);

/* tb_clkgen.sv */
// free-running 40 ns clock; reset is held low for 5 rising edges and released on a falling edge
module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 5;

  initial begin
    clk_o = 1'b0;
    forever #(CLK_PERIOD / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    // release away from the active edge
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* tb_controller.sv */
// reads controller_vectors.txt from the run directory; each vector line is one clock cycle
module tb_controller;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RST_CYCLES   = 5;
  // outputs are sampled 5 ns before the rising edge
  localparam int SAMPLE_DELAY = 15;

  logic clk;
  logic rst_n;

  // DUT inputs
  logic fetch_enable_i, illegal_insn_i, mret_insn_i, pipe_flush_i, instr_valid_i;
  logic data_req_ex_i, data_misaligned_i, mult_multicycle_i, branch_taken_ex_i;
  logic int_req_i, ext_req_i, id_ready_i, ex_valid_i;
  logic regfile_we_ex_i, regfile_we_wb_i, regfile_alu_we_fw_i;
  logic [ctrl_pkg::JUMP_W-1:0] jump_in_dec_i;
  logic reg_d_ex_is_reg_a_i, reg_d_ex_is_reg_b_i, reg_d_ex_is_reg_c_i;
  logic reg_d_wb_is_reg_a_i, reg_d_wb_is_reg_b_i, reg_d_wb_is_reg_c_i;
  logic reg_d_alu_is_reg_a_i, reg_d_alu_is_reg_b_i, reg_d_alu_is_reg_c_i;

  // DUT outputs
  logic ctrl_busy_o, is_decoding_o, deassert_we_o, instr_req_o, pc_set_o;
  logic [ctrl_pkg::PC_SEL_W-1:0] pc_mux_o;
  logic exc_ack_o, irq_ack_o, exc_save_if_o, exc_save_id_o, exc_save_takenbranch_o;
  logic exc_restore_id_o, halt_if_o, halt_id_o, jr_stall_o, load_stall_o;
  logic [ctrl_pkg::FWD_SEL_W-1:0] operand_a_fw_mux_sel_o;
  logic [ctrl_pkg::FWD_SEL_W-1:0] operand_b_fw_mux_sel_o;
  logic [ctrl_pkg::FWD_SEL_W-1:0] operand_c_fw_mux_sel_o;

  // one entry per vector line
  string       names_q[$];
  logic [15:0] ins_q[$];
  logic [1:0]  jump_q[$];
  logic [8:0]  match_q[$];
  logic [3:0]  pc_q[$];
  logic [5:0]  fwd_q[$];
  logic [2:0]  stall_q[$];
  logic [10:0] ctrl_q[$];

  int pc_errors, fwd_errors, stall_errors, ctrl_errors, file_errors;
  int cycle_count;
  int cycle_limit;

  tb_clkgen u_clkgen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  core_controller DUT (.*);

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  // bit order follows the column comments of the vector file
  task automatic drive_vector(input logic [15:0] ins, input logic [1:0] jmp,
                              input logic [8:0] mat);
    {fetch_enable_i, illegal_insn_i, mret_insn_i, pipe_flush_i, instr_valid_i,
     data_req_ex_i, data_misaligned_i, mult_multicycle_i, branch_taken_ex_i,
     int_req_i, ext_req_i, id_ready_i, ex_valid_i,
     regfile_we_ex_i, regfile_we_wb_i, regfile_alu_we_fw_i} = ins;
    jump_in_dec_i = jmp;
    {reg_d_ex_is_reg_a_i, reg_d_ex_is_reg_b_i, reg_d_ex_is_reg_c_i,
     reg_d_wb_is_reg_a_i, reg_d_wb_is_reg_b_i, reg_d_wb_is_reg_c_i,
     reg_d_alu_is_reg_a_i, reg_d_alu_is_reg_b_i, reg_d_alu_is_reg_c_i} = mat;
  endtask

  task automatic read_vectors();
    integer      fd;
    int          rc;
    int          fields;
    int          line_no;
    string       line;
    string       name;
    logic [15:0] ins;
    logic [1:0]  jmp;
    logic [8:0]  mat;
    logic [3:0]  e_pc;
    logic [5:0]  e_fwd;
    logic [2:0]  e_stall;
    logic [10:0] e_ctrl;
    line_no = 0;
    fd = $fopen("controller_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open the vector file controller_vectors.txt");
      file_errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      rc = $fgets(line, fd);
      line_no++;
      // skip blank and comment lines
      if (rc == 0 || line[0] == "#" || line[0] == "\n") continue;
      fields = $sscanf(line, "%s %b %b %b %b %b %b %b",
                       name, ins, jmp, mat, e_pc, e_fwd, e_stall, e_ctrl);
      if (fields <= 0) continue;
      if (fields != 8) begin
        $display("vector line %0d is incomplete, only %0d of 8 fields read", line_no, fields);
        file_errors++;
      end else begin
        names_q.push_back(name);
        ins_q.push_back(ins);
        jump_q.push_back(jmp);
        match_q.push_back(mat);
        pc_q.push_back(e_pc);
        fwd_q.push_back(e_fwd);
        stall_q.push_back(e_stall);
        ctrl_q.push_back(e_ctrl);
      end
    end
    $fclose(fd);
    if (names_q.size() == 0) begin
      $display("the vector file holds no vectors");
      file_errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // checks, one per kind of result
  //////////////////////////////////////////////////

  task automatic check_pc(input string name, input logic exp_set,
                          input logic [ctrl_pkg::PC_SEL_W-1:0] exp_mux);
    if (pc_set_o !== exp_set || pc_mux_o !== exp_mux) begin
      pc_errors++;
      $display("Fail %0s: pc_set/pc_mux expected %b/%b, actual %b/%b",
               name, exp_set, exp_mux, pc_set_o, pc_mux_o);
    end
  endtask

  task automatic check_fwd(input string name, input logic [ctrl_pkg::FWD_SEL_W-1:0] exp_a,
                           input logic [ctrl_pkg::FWD_SEL_W-1:0] exp_b,
                           input logic [ctrl_pkg::FWD_SEL_W-1:0] exp_c);
    if (operand_a_fw_mux_sel_o !== exp_a || operand_b_fw_mux_sel_o !== exp_b ||
        operand_c_fw_mux_sel_o !== exp_c) begin
      fwd_errors++;
      $display("Fail %0s: fwd a/b/c expected %b/%b/%b, actual %b/%b/%b", name,
               exp_a, exp_b, exp_c,
               operand_a_fw_mux_sel_o, operand_b_fw_mux_sel_o, operand_c_fw_mux_sel_o);
    end
  endtask

  task automatic check_stall(input string name, input logic exp_load, input logic exp_jr,
                             input logic exp_deassert);
    if (load_stall_o !== exp_load || jr_stall_o !== exp_jr ||
        deassert_we_o !== exp_deassert) begin
      stall_errors++;
      $display("Fail %0s: load/jr/deassert expected %b%b%b, actual %b%b%b", name,
               exp_load, exp_jr, exp_deassert, load_stall_o, jr_stall_o, deassert_we_o);
    end
  endtask

  // busy dec req ack irq save_if save_id save_tb restore hif hid
  task automatic check_ctrl(input string name, input logic [10:0] exp);
    logic [10:0] act;
    act = {ctrl_busy_o, is_decoding_o, instr_req_o, exc_ack_o, irq_ack_o,
           exc_save_if_o, exc_save_id_o, exc_save_takenbranch_o, exc_restore_id_o,
           halt_if_o, halt_id_o};
    if (act !== exp) begin
      ctrl_errors++;
      $display("Fail %0s: ctrl bits expected %b, actual %b", name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // run control
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      $display("timeout, the run passed its limit of %0d cycles", cycle_limit);
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    cycle_count = 0;
    cycle_limit = 0;
    drive_vector(16'h0000, 2'b00, 9'h000);
    read_vectors();
    cycle_limit = names_q.size() + RST_CYCLES + 20;
    if (names_q.size() != 0) begin
      wait (rst_n === 1'b1);
      foreach (names_q[i]) begin
        @(negedge clk);
        drive_vector(ins_q[i], jump_q[i], match_q[i]);
        // compare before the state register moves
        #(SAMPLE_DELAY);
        check_pc(names_q[i], pc_q[i][3], pc_q[i][2:0]);
        check_fwd(names_q[i], fwd_q[i][5:4], fwd_q[i][3:2], fwd_q[i][1:0]);
        check_stall(names_q[i], stall_q[i][2], stall_q[i][1], stall_q[i][0]);
        check_ctrl(names_q[i], ctrl_q[i]);
      end
    end
    $display("errors: pc %0d, fwd %0d, stall %0d, ctrl %0d, file %0d",
             pc_errors, fwd_errors, stall_errors, ctrl_errors, file_errors);
    if (pc_errors + fwd_errors + stall_errors + ctrl_errors + file_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* controller_vectors.txt */
# name ins(fe ill mret flush ival dreq mis mult br int ext idr exv wex wwb walu) jump(2)
# match(ex abc wb abc alu abc) pc(set mux) fwd(a b c) stall(ld jr dwe) ctrl(busy..halt_id)
reset_idle 0000000000000000 00 000000000 0000 000000 001 00000000000
boot_enable 1000000000000000 00 000000000 0000 000000 001 00000000000
boot_set 1000000000000000 00 000000000 1000 000000 001 10100000000
first_fetch_wait 1000000000000000 00 000000000 0000 000000 001 10100000000
first_fetch_go 1000000000010000 00 000000000 0000 000000 001 10100000000
jal_issue 1000100000000000 01 000000000 1010 000000 000 11100000000
jal_no_repeat 1000100000000000 01 000000000 0010 000000 000 11100000000
jal_release 1000100000010000 01 000000000 0010 000000 000 11100000000
jalr_stall 1000100000000100 10 100000000 0010 000000 011 11100000000
branch_taken 1000100010000000 00 000000000 1011 000000 001 10100000000
decode_nop 1000100000000000 00 000000000 0000 000000 000 11100000000
branch_ext_irq 1000100010100000 00 000000000 1100 000000 001 10111001001
int_exc 1000100001000000 00 000000000 1100 000000 000 11110010001
mret_return 1010100000010000 00 000000000 1101 000000 000 11100000100
load_use_b 1000110000000100 00 010000000 0000 000000 101 11100000000
illegal_insn 1100100000000000 00 000000000 0000 000000 001 11100000000
fwd_a_both 1000100000000011 00 000100100 0000 010000 000 11100000000
fwd_a_wb 1000100000000010 00 000100000 0000 100000 000 11100000000
fwd_misaligned 1000101000000011 00 000010010 0000 010000 000 11100000000
fwd_mult 1000100100000000 00 000000000 0000 000001 000 11100000000
wfi_flush 1001100000000000 00 000000000 0000 000000 000 11100000011
flush_ex_wait 0000000000000000 00 000000000 0000 000000 001 10100000011
flush_ex_hold 0000000000000000 00 000000000 0000 000000 001 10100000011
flush_ex_done 0000000000001000 00 000000000 0000 000000 001 10100000011
flush_wb 0000000000000000 00 000000000 0000 000000 001 10100000011
sleep 0000000000000000 00 000000000 0000 000000 001 00000000011
sleep_int_wake 0000000001000000 00 000000000 0000 000000 001 00000000011
wake_exc 0000000001000000 00 000000000 1100 000000 001 10110100000
wake_ext 0000000000110000 00 000000000 1100 000000 001 10111100000
decode_idle 0000000000000000 00 000000000 0000 000000 001 10100000000

/* build.f */
ctrl_pkg.sv
ctrl_fsm.sv
hazard_unit.sv
fwd_unit.sv
core_controller.sv
controller_props.sv
tb_clkgen.sv
tb_controller.sv

/* Makefile */
TOP := tb_controller

.PHONY: lint sim clean

lint:
	verilator --lint-only --top-module core_controller ctrl_pkg.sv ctrl_fsm.sv hazard_unit.sv fwd_unit.sv core_controller.sv
	verilator --lint-only --timing --top-module $(TOP) -f build.f

sim:
	verilator --binary --assert --top-module $(TOP) -f build.f -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
